// File: dv/decodeExecuteTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module decodeExecuteTb;
  import mipsPkg::*;

  // One line of the stimulus file, one clock cycle
  typedef struct packed {
    regWriteT               wr;
    logic                   instrValid;
    logic [`DATA_WIDTH-1:0] instr;
    logic                   stall;
    exMemT                  expected;
  } stimLineT;

  logic                   Clock;
  logic                   rst;
  logic                   instrValid;
  logic [`DATA_WIDTH-1:0] instr;
  regWriteT               wbWrite;
  logic                   stall;
  exMemT                  exOut;

  // Expected values handed to the checker
  logic  expStall;
  exMemT expOut;
  int    lineNo;
  int    testCount;
  int    errorCount;

  stimLineT lines[$];
  int       cycleCount;
  int       cycleLimit;

  decodeExecuteTop dut_i (
    .Clock      (Clock),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .wbWrite    (wbWrite),
    .stall      (stall),
    .exOut      (exOut)
  );

  executeChecker checker_i (
    .Clock      (Clock),
    .rst        (rst),
    .stall      (stall),
    .exOut      (exOut),
    .expStall   (expStall),
    .expOut     (expOut),
    .lineNo     (lineNo),
    .testCount  (testCount),
    .errorCount (errorCount)
  );

  // 8 ns clock
  initial begin
    Clock = 1'b0;
    forever #4 Clock = ~Clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  // Header and blank lines fail the scan and are skipped
  task automatic loadStimulus();
    int                     fd;
    int                     fields;
    logic [8*160-1:0]       lineBuf;
    logic                   wen;
    logic [4:0]             waddr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic                   iv;
    logic [`DATA_WIDTH-1:0] ins;
    logic                   stl;
    logic                   tag;
    logic [7:0]             ctrlByte;
    logic [4:0]             dest;
    logic [`DATA_WIDTH-1:0] result;
    logic [`DATA_WIDTH-1:0] store;
    stimLineT               entry;
    fd = $fopen("dv/decodeExecute_stimulus.txt", "r");
    if (fd != 0) begin
      while ($fgets(lineBuf, fd) != 0) begin
        fields = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %h %h", wen, waddr, wdata,
                         iv, ins, stl, tag, ctrlByte, dest, result, store);
        if (fields == 11) begin
          entry = '0;
          entry.wr.en      = wen;
          entry.wr.addr    = waddr;
          entry.wr.data    = wdata;
          entry.instrValid = iv;
          entry.instr      = ins;
          entry.stall      = stl;
          // Tag low means a bubble, only control fields matter then
          entry.expected.instrValid = tag;
          if (tag) begin
            entry.expected.wb        = wbCtrlT'(ctrlByte[7:6]);
            entry.expected.mem       = memCtrlT'(ctrlByte[5:0]);
            entry.expected.aluResult = result;
            entry.expected.storeData = store;
            entry.expected.destReg   = dest;
          end
          lines.push_back(entry);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic driveLine(input stimLineT entry, input int num);
    wbWrite    = entry.wr;
    instrValid = entry.instrValid;
    instr      = entry.instr;
    expStall   = entry.stall;
    expOut     = entry.expected;
    lineNo     = num;
  endtask

  // Empty cycle while the pipe drains
  task automatic driveIdle(input int num);
    wbWrite    = '0;
    instrValid = 1'b0;
    instr      = '0;
    expStall   = 1'b0;
    expOut     = '0;
    lineNo     = num;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    wbWrite    = '0;
    expStall   = 1'b0;
    expOut     = '0;
    lineNo     = 0;
    cycleLimit = 0;
    loadStimulus();
    if (lines.size() == 0) begin
      $display("Stimulus file is missing or holds no data lines");
      $display("Checks failed");
      $finish;
    end else begin
      cycleLimit = lines.size() + 20;
      repeat (5) @(posedge Clock);
      #1;
      rst = 1'b0;
      // Inputs change 1 ns after each rising edge
      for (int i = 0; i < lines.size(); i++) begin
        driveLine(lines[i], i + 1);
        @(posedge Clock);
        #1;
      end
      // Two more cycles bring the last results to exOut
      for (int i = 0; i < 2; i++) begin
        driveIdle(lines.size() + 1 + i);
        @(posedge Clock);
        #1;
      end
      if (testCount != lines.size() + 2) begin
        $display("Only %0d of %0d tests were compared", testCount, lines.size() + 2);
      end
      $display("Tests run: %0d, errors: %0d", testCount, errorCount);
      if (errorCount == 0 && testCount == lines.size() + 2) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  // Cycle budget from the number of stimulus lines
  initial begin
    cycleCount = 0;
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge Clock);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/decodeExecute_stimulus.txt
# hex columns: wbEn wbAddr wbData instrValid instr expStall expTag expCtrl expDest expResult expStore
# expCtrl is {regWrite memToReg memRead memWrite readWidth writeWidth}, expTag 0 expects a bubble
1 01 00000005 0 00000000 0 0 00 00 00000000 00000000
1 02 00000003 0 00000000 0 0 00 00 00000000 00000000
1 03 7fffffff 0 00000000 0 0 00 00 00000000 00000000
1 04 fffffff0 0 00000000 0 0 00 00 00000000 00000000
1 05 80000000 0 00000000 0 0 00 00 00000000 00000000
0 00 00000000 1 00223020 0 1 80 06 00000008 00000003
0 00 00000000 1 00413822 0 1 80 07 fffffffe 00000005
0 00 00000000 1 00614020 0 1 80 08 80000004 00000005
0 00 00000000 1 00644824 0 1 80 09 7ffffff0 fffffff0
0 00 00000000 1 00225025 0 1 80 0a 00000007 00000003
0 00 00000000 1 0081582a 0 1 80 0b 00000001 00000005
0 00 00000000 1 0024602a 0 1 80 0c 00000000 fffffff0
0 00 00000000 1 202dfff9 0 1 80 0d fffffffe 00000000
0 00 00000000 1 288effff 0 1 80 0e 00000001 00000000
0 00 00000000 1 308fff0f 0 1 80 0f 0000ff00 00000000
0 00 00000000 1 34308000 0 1 80 10 00008005 00000000
0 00 00000000 1 3c11abcd 0 1 80 11 abcd0000 00000000
0 00 00000000 1 00019100 0 1 80 12 00000050 00000005
0 00 00000000 1 00049a02 0 1 80 13 00ffffff fffffff0
1 00 12345678 1 0001a020 0 1 80 14 00000005 00000005
1 02 00000100 1 0041a820 0 1 80 15 00000105 00000005
0 00 00000000 1 0002b025 0 1 80 16 00000100 00000100
0 00 00000000 1 8c250008 0 1 e8 05 0000000d 80000000
0 00 00000000 1 00a1b820 1 0 00 00 00000000 00000000
0 00 00000000 1 00a1b820 0 1 80 17 80000005 00000005
0 00 00000000 1 ac22fffc 0 1 12 02 00000001 00000100
0 00 00000000 1 8c460010 0 1 e8 06 00000110 00000000
0 00 00000000 1 0022c025 0 1 80 18 00000105 00000100
0 00 00000000 1 8c200004 0 1 e8 00 00000009 00000000
0 00 00000000 1 0001c820 0 1 80 19 00000005 00000005
0 00 00000000 1 8c070000 0 1 e8 07 00000000 00000000
0 00 00000000 1 0027d022 1 0 00 00 00000000 00000000
0 00 00000000 1 0027d022 0 1 80 1a 00000005 00000000
0 00 00000000 0 ffffffff 0 0 00 00 00000000 00000000
0 00 00000000 1 fc000000 0 0 00 00 00000000 00000000

// File: dv/executeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module executeChecker (
  input  logic           Clock,
  input  logic           rst,
  input  logic           stall,
  input  mipsPkg::exMemT exOut,
  input  logic           expStall,
  input  mipsPkg::exMemT expOut,
  input  int             lineNo,
  output int             testCount,
  output int             errorCount
);
  import mipsPkg::*;

  // Expectation waiting for its result
  typedef struct packed {
    exMemT       expected;
    logic [15:0] srcLine;
    logic        stallOk;
  } pendingT;

  // Two deep with one entry per pipeline stage
  pendingT pending[$];
  pendingT head;
  logic    stallOk;

  ////////////////////////////////////////////////////////////////////////////
  // Result compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic compareResult(input pendingT entry);
    logic ok;
    ok = entry.stallOk;
    if (entry.expected.instrValid) begin
      // Full bundle for a valid instruction
      if (exOut !== entry.expected) begin
        ok = 1'b0;
        errorCount++;
        $write("Fail at %0d ns: line %0d exOut result %h dest %0d store %h ctrl %b_%b",
               $time, entry.srcLine, exOut.aluResult, exOut.destReg, exOut.storeData,
               exOut.wb, exOut.mem);
        $display(" valid %b, expected result %h dest %0d store %h ctrl %b_%b valid 1",
                 exOut.instrValid, entry.expected.aluResult, entry.expected.destReg,
                 entry.expected.storeData, entry.expected.wb, entry.expected.mem);
      end
    end else if ({exOut.wb, exOut.mem, exOut.instrValid} !== '0) begin
      // Bubble compares control fields only
      ok = 1'b0;
      errorCount++;
      $display("Fail at %0d ns: line %0d expected a bubble, exOut ctrl %b_%b valid %b",
               $time, entry.srcLine, exOut.wb, exOut.mem, exOut.instrValid);
    end
    testCount++;
    if (entry.srcLine == 0) begin
      if (ok) begin
        $display("Test reset state: ok");
      end else begin
        $display("Test reset state: mismatch");
      end
    end else begin
      if (ok) begin
        $display("Test line %0d: ok", entry.srcLine);
      end else begin
        $display("Test line %0d: mismatch", entry.srcLine);
      end
    end
  endtask

  // Sample at negedge where inputs and registers have settled
  always @(negedge Clock) begin
    if (rst) begin
      testCount  = 0;
      errorCount = 0;
      pending.delete();
      // Reset state reaches exOut for the first two cycles
      head = '0;
      head.stallOk = 1'b1;
      pending.push_back(head);
      pending.push_back(head);
    end else begin
      stallOk = (stall === expStall);
      if (!stallOk) begin
        errorCount++;
        $display("Fail at %0d ns: line %0d stall is %b, expected %b",
                 $time, lineNo, stall, expStall);
      end
      if (pending.size() != 0) begin
        head = pending.pop_front();
        compareResult(head);
      end
      head.expected = expOut;
      head.srcLine  = 16'(lineNo);
      head.stallOk  = stallOk;
      pending.push_back(head);
    end
  end

endmodule

`default_nettype wire

// File: hdl/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module controlDecoder (
  input  logic                       instrValid,
  input  logic [`DATA_WIDTH-1:0]     instr,
  output mipsPkg::ctrlT              ctrl,
  output logic [`REG_ADDR_WIDTH-1:0] rs,
  output logic [`REG_ADDR_WIDTH-1:0] rt,
  output logic [`REG_ADDR_WIDTH-1:0] rd,
  output logic [4:0]                 shamt,
  output logic [`DATA_WIDTH-1:0]     imm32
);
  import mipsPkg::*;

  opcodeT opcode;
  functT  funct;
  // Cleared for any encoding outside the supported set
  logic   legal;
  logic   zeroExt;

  // Raw instruction fields
  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = functT'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];

  // Logical immediates are zero-extended
  assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_LUI);
  assign imm32   = zeroExt ? {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr[`IMM_WIDTH-1:0]}
                           : {{(`DATA_WIDTH-`IMM_WIDTH){instr[`IMM_WIDTH-1]}},
                              instr[`IMM_WIDTH-1:0]};

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl  = '0;
    legal = 1'b1;
    case (opcode)
      OP_RTYPE: begin
        ctrl.wb.regWrite = 1'b1;
        // Destination in rd
        ctrl.ex.regDst  = 1'b1;
        ctrl.ex.aluSrc1 = OPB_REG;
        case (funct)
          FN_ADD: ctrl.ex.aluOp = ALU_ADD;
          FN_SUB: ctrl.ex.aluOp = ALU_SUB;
          FN_AND: ctrl.ex.aluOp = ALU_AND;
          FN_OR:  ctrl.ex.aluOp = ALU_OR;
          FN_SLT: ctrl.ex.aluOp = ALU_SLT;
          // Shifts take shamt as operand A
          FN_SLL: begin
            ctrl.ex.aluOp   = ALU_SLL;
            ctrl.ex.aluSrc0 = 1'b1;
          end
          FN_SRL: begin
            ctrl.ex.aluOp   = ALU_SRL;
            ctrl.ex.aluSrc0 = 1'b1;
          end
          default: legal = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.wb.regWrite = 1'b1;
        ctrl.ex.aluSrc1  = OPB_SEXT;
        ctrl.ex.aluOp    = ALU_ADD;
      end
      OP_SLTI: begin
        ctrl.wb.regWrite = 1'b1;
        ctrl.ex.aluSrc1  = OPB_SEXT;
        ctrl.ex.aluOp    = ALU_SLT;
      end
      OP_ANDI: begin
        ctrl.wb.regWrite = 1'b1;
        ctrl.ex.aluSrc1  = OPB_ZEXT;
        ctrl.ex.aluOp    = ALU_AND;
      end
      OP_ORI: begin
        ctrl.wb.regWrite = 1'b1;
        ctrl.ex.aluSrc1  = OPB_ZEXT;
        ctrl.ex.aluOp    = ALU_OR;
      end
      OP_LUI: begin
        ctrl.wb.regWrite = 1'b1;
        ctrl.ex.aluSrc1  = OPB_ZEXT;
        ctrl.ex.aluOp    = ALU_LUI;
      end
      // Loads write back from memory
      OP_LW: begin
        ctrl.wb.regWrite      = 1'b1;
        ctrl.wb.memToReg      = 1'b1;
        ctrl.mem.memRead      = 1'b1;
        ctrl.mem.readWidth    = WIDTH_WORD;
        ctrl.ex.aluSrc1       = OPB_SEXT;
        ctrl.ex.aluOp         = ALU_ADD;
      end
      // Stores only compute the address
      OP_SW: begin
        ctrl.mem.memWrite     = 1'b1;
        ctrl.mem.writeWidth   = WIDTH_WORD;
        ctrl.ex.aluSrc1       = OPB_SEXT;
        ctrl.ex.aluOp         = ALU_ADD;
      end
      default: legal = 1'b0;
    endcase
    ctrl.ex.instrValid = 1'b1;
    // Unknown or absent instruction becomes a bubble
    if (!legal || !instrValid) begin
      ctrl = '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/decodeExecuteTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module decodeExecuteTop (
  input  logic                   Clock,
  input  logic                   rst,
  input  logic                   instrValid,
  input  logic [`DATA_WIDTH-1:0] instr,
  input  mipsPkg::regWriteT      wbWrite,
  output logic                   stall,
  output mipsPkg::exMemT         exOut
);
  import mipsPkg::*;

  // Decode bundle heading into ID/EX
  idExT  idExIn;
  idExT  idExOut;
  // Execute result heading into EX/MEM
  exMemT exMemIn;

  ////////////////////////////////////////////////////////////////////////////
  // Decode stage
  ////////////////////////////////////////////////////////////////////////////

  controlDecoder decoder_i (
    .instrValid (instrValid),
    .instr      (instr),
    .ctrl       (idExIn.ctrl),
    .rs         (idExIn.rs),
    .rt         (idExIn.rt),
    .rd         (idExIn.rd),
    .shamt      (idExIn.shamt),
    .imm32      (idExIn.imm32)
  );

  // Operands for the decoder's rs and rt
  registerFile regFile_i (
    .Clock     (Clock),
    .rst       (rst),
    .wbWrite   (wbWrite),
    .readAddr1 (idExIn.rs),
    .readAddr2 (idExIn.rt),
    .readData1 (idExIn.regData1),
    .readData2 (idExIn.regData2)
  );

  // Load-use check against ID/EX
  hazardDetect hazard_i (
    .Clock      (Clock),
    .rst        (rst),
    .instrValid (instrValid),
    .rs         (idExIn.rs),
    .rt         (idExIn.rt),
    .exStage    (idExOut),
    .stall      (stall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute stage
  ////////////////////////////////////////////////////////////////////////////

  // Stall turns the captured bundle into a bubble
  decodeToExecute #(.payloadT(idExT)) idExReg_i (
    .Clock    (Clock),
    .rst      (rst),
    .bubble   (stall),
    .stageIn  (idExIn),
    .stageOut (idExOut)
  );

  executeUnit execute_i (
    .Clock    (Clock),
    .rst      (rst),
    .stageIn  (idExOut),
    .stageOut (exMemIn)
  );

  // No downstream back-pressure
  decodeToExecute #(.payloadT(exMemT)) exMemReg_i (
    .Clock    (Clock),
    .rst      (rst),
    .bubble   (1'b0),
    .stageIn  (exMemIn),
    .stageOut (exOut)
  );

endmodule

`default_nettype wire

// File: hdl/decodeToExecute.sv
`timescale 1ns/1ps
`default_nettype none

module decodeToExecute #(
  parameter type payloadT = logic
) (
  input  logic    Clock,
  input  logic    rst,
  input  logic    bubble,
  input  payloadT stageIn,
  output payloadT stageOut
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  // All-zero payload is an invalid bubble
  always_ff @(posedge Clock) begin
    if (rst || bubble) begin
      stageOut <= '0;
    end else begin
      stageOut <= stageIn;
    end
  end

endmodule

`default_nettype wire

// File: hdl/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module executeUnit (
  input  logic           Clock,
  input  logic           rst,
  input  mipsPkg::idExT  stageIn,
  output mipsPkg::exMemT stageOut
);
  import mipsPkg::*;

  localparam int SHIFT_WIDTH = $clog2(`DATA_WIDTH);
  localparam int HALF_WIDTH  = `DATA_WIDTH / 2;

  logic [`DATA_WIDTH-1:0] operandA;
  logic [`DATA_WIDTH-1:0] operandB;
  logic [SHIFT_WIDTH-1:0] shiftAmt;
  logic [`DATA_WIDTH-1:0] aluResult;

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////////////////////

  // Shift amount replaces rs data for sll and srl
  assign operandA = stageIn.ctrl.ex.aluSrc0
                  ? {{(`DATA_WIDTH-5){1'b0}}, stageIn.shamt}
                  : stageIn.regData1;

  always_comb begin
    case (stageIn.ctrl.ex.aluSrc1)
      OPB_SEXT: operandB = {{(`DATA_WIDTH-HALF_WIDTH){stageIn.imm32[HALF_WIDTH-1]}},
                            stageIn.imm32[HALF_WIDTH-1:0]};
      OPB_ZEXT: operandB = {{(`DATA_WIDTH-HALF_WIDTH){1'b0}},
                            stageIn.imm32[HALF_WIDTH-1:0]};
      default:  operandB = stageIn.regData2;
    endcase
  end

  assign shiftAmt = operandA[SHIFT_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (stageIn.ctrl.ex.aluOp)
      // Add and subtract wrap
      ALU_ADD: aluResult = operandA + operandB;
      ALU_SUB: aluResult = operandA - operandB;
      ALU_AND: aluResult = operandA & operandB;
      ALU_OR:  aluResult = operandA | operandB;
      // Signed compare
      ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}},
                            ($signed(operandA) < $signed(operandB))};
      ALU_SLL: aluResult = operandB << shiftAmt;
      ALU_SRL: aluResult = operandB >> shiftAmt;
      // Immediate into upper half
      ALU_LUI: aluResult = {operandB[HALF_WIDTH-1:0], {HALF_WIDTH{1'b0}}};
      default: aluResult = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM bundle
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stageOut.wb         = stageIn.ctrl.wb;
    stageOut.mem        = stageIn.ctrl.mem;
    stageOut.instrValid = stageIn.ctrl.ex.instrValid;
    stageOut.aluResult  = aluResult;
    // sw writes the rt value
    stageOut.storeData  = stageIn.regData2;
    stageOut.destReg    = stageIn.ctrl.ex.regDst ? stageIn.rd : stageIn.rt;
  end

  // Decoder and ID/EX never deliver a read and a write together
  assert property (@(posedge Clock) disable iff (rst)
    !(stageIn.ctrl.mem.memRead && stageIn.ctrl.mem.memWrite));

endmodule

`default_nettype wire

// File: hdl/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module hazardDetect (
  input  logic                       Clock,
  input  logic                       rst,
  input  logic                       instrValid,
  input  logic [`REG_ADDR_WIDTH-1:0] rs,
  input  logic [`REG_ADDR_WIDTH-1:0] rt,
  input  mipsPkg::idExT              exStage,
  output logic                       stall
);

  // Live load sitting in ID/EX
  logic loadInEx;
  // Incoming source matches the load target
  logic srcMatch;

  assign loadInEx = exStage.ctrl.mem.memRead && exStage.ctrl.ex.instrValid;
  // Register 0 never carries a dependency
  assign srcMatch = (exStage.rt != '0) && ((exStage.rt == rs) || (exStage.rt == rt));
  assign stall    = instrValid && loadInEx && srcMatch;

  // The bubble inserted on a stall removes the load from ID/EX
  assert property (@(posedge Clock) disable iff (rst) stall |=> !stall);

endmodule

`default_nettype wire

// File: hdl/mipsCore_macros.svh
`ifndef MIPSCORE_MACROS_SVH
`define MIPSCORE_MACROS_SVH

// Datapath width in bits
`define DATA_WIDTH 32

// Register index width
`define REG_ADDR_WIDTH 5

// Architectural register count
`define REG_COUNT 32

// Immediate field width in the instruction word
`define IMM_WIDTH 16

`endif

// File: hdl/mipsPkg.sv
`default_nettype none

`include "mipsCore_macros.svh"

package mipsPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Primary opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_SLTI  = 6'h0A,
    OP_ANDI  = 6'h0C,
    OP_ORI   = 6'h0D,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcodeT;

  // R-type function codes, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2A
  } functT;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } aluOpT;

  // Operand B source
  typedef enum logic [1:0] {
    OPB_REG  = 2'd0,
    OPB_SEXT = 2'd1,
    OPB_ZEXT = 2'd2
  } operandBSelT;

  // Memory access width code, word only here
  localparam logic [1:0] WIDTH_WORD = 2'd2;

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////////////

  // External register write port
  typedef struct packed {
    logic                       en;
    logic [`REG_ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0]     data;
  } regWriteT;

  // Writeback group
  typedef struct packed {
    logic regWrite;
    logic memToReg;
  } wbCtrlT;

  // Memory group
  typedef struct packed {
    logic       memRead;
    logic       memWrite;
    logic [1:0] readWidth;
    logic [1:0] writeWidth;
  } memCtrlT;

  // Execute group, carries the valid flag
  typedef struct packed {
    logic        regDst;
    logic        aluSrc0;
    operandBSelT aluSrc1;
    aluOpT       aluOp;
    logic        instrValid;
  } exCtrlT;

  typedef struct packed {
    wbCtrlT  wb;
    memCtrlT mem;
    exCtrlT  ex;
  } ctrlT;

  // ID/EX contents
  typedef struct packed {
    ctrlT                       ctrl;
    logic [4:0]                 shamt;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     regData1;
    logic [`DATA_WIDTH-1:0]     regData2;
    logic [`DATA_WIDTH-1:0]     imm32;
  } idExT;

  // EX/MEM contents
  typedef struct packed {
    wbCtrlT                     wb;
    memCtrlT                    mem;
    logic                       instrValid;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic [`DATA_WIDTH-1:0]     storeData;
    logic [`REG_ADDR_WIDTH-1:0] destReg;
  } exMemT;

endpackage

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_macros.svh"

module registerFile (
  input  logic                       Clock,
  input  logic                       rst,
  input  mipsPkg::regWriteT          wbWrite,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
  input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
  output logic [`DATA_WIDTH-1:0]     readData1,
  output logic [`DATA_WIDTH-1:0]     readData2
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Register 0 is never written
  always_ff @(posedge Clock) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite.en && (wbWrite.addr != '0)) begin
      regs[wbWrite.addr] <= wbWrite.data;
    end
  end

  // Read ports with write-through bypass
  always_comb begin
    if (readAddr1 == '0) begin
      readData1 = '0;
    end else if (wbWrite.en && (wbWrite.addr == readAddr1)) begin
      readData1 = wbWrite.data;
    end else begin
      readData1 = regs[readAddr1];
    end
    if (readAddr2 == '0) begin
      readData2 = '0;
    end else if (wbWrite.en && (wbWrite.addr == readAddr2)) begin
      readData2 = wbWrite.data;
    end else begin
      readData2 = regs[readAddr2];
    end
  end

  // A write aimed at register 0 leaves it zero
  assert property (@(posedge Clock) disable iff (rst)
    (wbWrite.en && (wbWrite.addr == '0)) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module decodeExecuteTb \
  -o decodeExecuteSim
./obj_dir/decodeExecuteSim > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: sources.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/hazardDetect.sv
hdl/decodeToExecute.sv
hdl/executeUnit.sv
hdl/decodeExecuteTop.sv
dv/executeChecker.sv
dv/decodeExecuteTb.sv
